// File: mapper_macros.svh
// Build constants for the memory mapper.
// Include wherever region counts, register counts or command codes are needed.
`ifndef MAPPER_MACROS_SVH
`define MAPPER_MACROS_SVH

// address regions in the decoder
`define MAP_REGIONS 8

// bytes in the register file
`define MAP_NREGS 32

// word address width, bus address runs [MAP_AW:1]
`define MAP_AW 23

// transfer commands in bits 1..0 of register 5
`define CMD_WRITE 2'd1
`define CMD_READ  2'd2

`endif

// File: mapper_pkg.sv
// Shared types for the memory mapper.
// Modules name these by scope in port lists and import the package in their bodies.
`default_nettype none

package mapper_pkg;

    // acknowledge delay selected by a region
    typedef enum logic [1:0] {
        WAIT_1   = 2'd0,
        WAIT_2   = 2'd1,
        WAIT_3   = 2'd2,
        WAIT_EXT = 2'd3     // hold until the external acknowledge
    } wait_code_t;

    typedef struct packed {
        logic [3:0] rsvd;
        wait_code_t wait_code;
        logic [1:0] size_code;  // 64k, 128k, 512k, 2048k
    } region_fields_t;

    // region control byte, seen raw by the register file and as fields by the decoder
    typedef union packed {
        logic [7:0]     raw;
        region_fields_t f;
    } region_ctrl_t;

    // transfer engine states
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        REQ  = 2'd1,
        DONE = 2'd2
    } xfer_state_t;

endpackage

`default_nettype wire

// File: mapper_regs.sv
// AXI4-Lite slave holding the 32-byte mapper register file.
// Writes to the command register start a bus transfer when the engine is idle,
// and completed reads load the transfer data registers.
`timescale 1ns/10ps
`default_nettype none
`include "mapper_macros.svh"

module mapper_regs (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [4:0]           awaddr,
    input  wire logic                 awvalid,
    output logic                      awready,
    input  wire logic [31:0]          wdata,
    input  wire logic [3:0]           wstrb,
    input  wire logic                 wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  wire logic                 bready,
    input  wire logic [4:0]           araddr,
    input  wire logic                 arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  wire logic                 rready,
    input  wire logic                 busy,
    input  wire logic                 load_data,
    input  wire logic [15:0]          xfer_rdata,
    output mapper_pkg::region_ctrl_t  region_ctrl [0:`MAP_REGIONS-1],
    output logic [7:0]                region_base [0:`MAP_REGIONS-1],
    output logic [`MAP_AW:1]          rd_addr,
    output logic [`MAP_AW:1]          wr_addr,
    output logic [15:0]               wr_data,
    output logic                      start_read,
    output logic                      start_write
);

    localparam logic [4:0] CMD_REG = 5'd5;

    logic [7:0] regs [0:`MAP_NREGS-1];
    logic       wr_hs;
    logic [7:0] rd_byte;

    assign wr_hs   = awvalid && wvalid && awready;  // wready moves with awready
    assign rd_byte = (araddr == CMD_REG) ? {busy, regs[CMD_REG][6:0]} : regs[araddr];
    assign bresp   = 2'b00;
    assign rresp   = 2'b00;

    assign rd_addr = {regs[7][6:0], regs[8], regs[9]};
    assign wr_addr = {regs[10][6:0], regs[11], regs[12]};
    assign wr_data = {regs[0], regs[1]};

    // control bytes at even addresses from 16, bases just after
    for (genvar r = 0; r < `MAP_REGIONS; r++) begin : g_region
        assign region_ctrl[r] = regs[16 + 2*r];
        assign region_base[r] = regs[17 + 2*r];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MAP_NREGS; i++) begin
                regs[i] <= 8'd0;
            end
            awready     <= 1'b0;
            wready      <= 1'b0;
            bvalid      <= 1'b0;
            arready     <= 1'b0;
            rvalid      <= 1'b0;
            start_read  <= 1'b0;
            start_write <= 1'b0;
        end else begin
            start_read  <= 1'b0;
            start_write <= 1'b0;

            // one-cycle ready once both address and data are offered
            awready <= awvalid && wvalid && !bvalid && !awready;
            wready  <= awvalid && wvalid && !bvalid && !awready;

            if (wr_hs) begin
                bvalid <= 1'b1;
                if (wstrb[0]) begin
                    regs[awaddr] <= wdata[7:0];
                    if (awaddr == CMD_REG && !busy) begin  // ignored while running
                        start_write <= (wdata[1:0] == `CMD_WRITE);
                        start_read  <= (wdata[1:0] == `CMD_READ);
                    end
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end

            // read data from the engine overrides a software write
            if (load_data) begin
                {regs[0], regs[1]} <= xfer_rdata;
            end

            arready <= arvalid && !rvalid && !arready;
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata <= {24'd0, rd_byte};
        end
    end

    a_one_start: assert property (@(posedge clk) disable iff (rst)
        !(start_read && start_write));

endmodule

`default_nettype wire

// File: region_decode.sv
// Priority decoder for the eight mapper regions.
// Purely combinational: matches the bus address against each base byte at the
// programmed region size, lowest region first.
`timescale 1ns/10ps
`default_nettype none
`include "mapper_macros.svh"

module region_decode (
    input  wire logic [`MAP_AW:1]          bus_addr,
    input  wire mapper_pkg::region_ctrl_t  region_ctrl [0:`MAP_REGIONS-1],
    input  wire logic [7:0]                region_base [0:`MAP_REGIONS-1],
    output logic [`MAP_REGIONS-1:0]        active,
    output logic                           none,
    output logic [1:0]                     wait_code
);

    import mapper_pkg::*;

    always_comb begin
        region_ctrl_t ctrl;
        logic         hit;

        active    = '0;
        wait_code = 2'd0;  // default when nothing matches
        for (int r = 0; r < `MAP_REGIONS; r++) begin
            ctrl = region_ctrl[r];
            case (ctrl.f.size_code)
                2'd0:    hit = bus_addr[`MAP_AW -: 8] == region_base[r];       // 64 kB
                2'd1:    hit = bus_addr[`MAP_AW -: 7] == region_base[r][7:1];  // 128 kB
                2'd2:    hit = bus_addr[`MAP_AW -: 5] == region_base[r][7:3];  // 512 kB
                default: hit = bus_addr[`MAP_AW -: 3] == region_base[r][7:5];  // 2048 kB
            endcase
            if (hit && active == '0) begin
                active[r] = 1'b1;
                wait_code = ctrl.f.wait_code;
            end
        end
        none = (active == '0);
    end

    // the timer trusts a single winner
    always_comb begin
        a_onehot: assert ($onehot0(active) && (none == (active == '0)));
    end

endmodule

`default_nettype wire

// File: wait_timer.sv
// Data acknowledge timer for CPU bus cycles.
// Counts from the start of each asn cycle and drops dtackn after the number of
// cycles given by the region's wait code, or on ext_ack for code 3.
`timescale 1ns/10ps
`default_nettype none

module wait_timer (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       asn,
    input  wire logic       ext_ack,
    input  wire logic [1:0] wait_code,
    output logic            dtackn
);

    import mapper_pkg::*;

    logic [1:0] cnt;
    logic [1:0] target;

    assign target = wait_code + 2'd1;  // 1..3 cycles for codes 0..2

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt    <= 2'd0;
            dtackn <= 1'b1;
        end else if (asn) begin
            cnt    <= 2'd0;  // bus cycle over
            dtackn <= 1'b1;
        end else if (dtackn) begin
            if (wait_code == WAIT_EXT) begin
                if (ext_ack) begin
                    dtackn <= 1'b0;
                end
            end else if (cnt == target) begin
                dtackn <= 1'b0;
            end else begin
                cnt <= cnt + 2'd1;
            end
        end
    end

    a_release: assert property (@(posedge clk) disable iff (rst) asn |=> dtackn);

endmodule

`default_nettype wire

// File: xfer_fsm.sv
// Single-word transfer engine driven by the command register.
// Runs one memory request per command and owns the bus address while busy.
`timescale 1ns/10ps
`default_nettype none
`include "mapper_macros.svh"

module xfer_fsm (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic [`MAP_AW:1]  cpu_addr,
    input  wire logic              start_read,
    input  wire logic              start_write,
    input  wire logic [`MAP_AW:1]  rd_addr,
    input  wire logic [`MAP_AW:1]  wr_addr,
    input  wire logic [15:0]       wr_data,
    input  wire logic              mem_ack,
    input  wire logic [15:0]       mem_rdata,
    output logic [`MAP_AW:1]       bus_addr,
    output logic                   mem_req,
    output logic                   mem_we,
    output logic [15:0]            mem_wdata,
    output logic                   busy,
    output logic                   load_data,
    output logic [15:0]            xfer_rdata
);

    import mapper_pkg::*;

    xfer_state_t       state;
    logic [`MAP_AW:1]  xfer_addr;

    assign busy     = (state != IDLE);
    assign bus_addr = busy ? xfer_addr : cpu_addr;  // engine takes the bus

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            mem_req   <= 1'b0;
            mem_we    <= 1'b0;
            load_data <= 1'b0;
        end else begin
            load_data <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_read || start_write) begin
                        state   <= REQ;
                        mem_req <= 1'b1;
                        mem_we  <= start_write;
                    end
                end
                REQ: begin
                    if (mem_ack) begin
                        state     <= DONE;
                        mem_req   <= 1'b0;
                        load_data <= !mem_we;  // only reads return data
                    end
                end
                default: state <= IDLE;  // DONE lasts one cycle
            endcase
        end
    end

    // address and data are latched at start so software may reprogram them
    always_ff @(posedge clk) begin
        if (state == IDLE && (start_read || start_write)) begin
            xfer_addr <= start_write ? wr_addr : rd_addr;
            mem_wdata <= wr_data;
        end
        if (state == REQ && mem_ack) begin
            xfer_rdata <= mem_rdata;
        end
    end

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |=> mem_req);

endmodule

`default_nettype wire

// File: mapper_top.sv
// Memory mapper top level.
// Register file on AXI4-Lite, region decode and DTACK timing on the CPU bus,
// and a simple req/ack port for software-driven transfers.
`timescale 1ns/10ps
`default_nettype none
`include "mapper_macros.svh"

module mapper_top (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [4:0]            awaddr,
    input  wire logic                  awvalid,
    output logic                       awready,
    input  wire logic [31:0]           wdata,
    input  wire logic [3:0]            wstrb,
    input  wire logic                  wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  wire logic                  bready,
    input  wire logic [4:0]            araddr,
    input  wire logic                  arvalid,
    output logic                       arready,
    output logic [31:0]                rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  wire logic                  rready,
    input  wire logic [`MAP_AW:1]      addr,
    input  wire logic                  asn,
    input  wire logic                  ext_ack,
    output logic                       dtackn,
    output logic [`MAP_REGIONS-1:0]    active,
    output logic                       none,
    output logic [`MAP_AW:1]           bus_addr,
    output logic                       mem_req,
    output logic                       mem_we,
    output logic [15:0]                mem_wdata,
    input  wire logic                  mem_ack,
    input  wire logic [15:0]           mem_rdata
);

    import mapper_pkg::*;

    region_ctrl_t      region_ctrl [0:`MAP_REGIONS-1];
    logic [7:0]        region_base [0:`MAP_REGIONS-1];
    logic [`MAP_AW:1]  rd_addr;
    logic [`MAP_AW:1]  wr_addr;
    logic [15:0]       wr_data;
    logic              start_read;
    logic              start_write;
    logic              busy;
    logic              load_data;
    logic [15:0]       xfer_rdata;
    logic [1:0]        wait_code;   // from the winning region

    mapper_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .busy        (busy),
        .load_data   (load_data),
        .xfer_rdata  (xfer_rdata),
        .region_ctrl (region_ctrl),
        .region_base (region_base),
        .rd_addr     (rd_addr),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .start_read  (start_read),
        .start_write (start_write)
    );

    region_decode u_decode (
        .bus_addr    (bus_addr),
        .region_ctrl (region_ctrl),
        .region_base (region_base),
        .active      (active),
        .none        (none),
        .wait_code   (wait_code)
    );

    wait_timer u_wait (
        .clk       (clk),
        .rst       (rst),
        .asn       (asn),
        .ext_ack   (ext_ack),
        .wait_code (wait_code),
        .dtackn    (dtackn)
    );

    xfer_fsm u_xfer (
        .clk         (clk),
        .rst         (rst),
        .cpu_addr    (addr),
        .start_read  (start_read),
        .start_write (start_write),
        .rd_addr     (rd_addr),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .bus_addr    (bus_addr),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_wdata   (mem_wdata),
        .busy        (busy),
        .load_data   (load_data),
        .xfer_rdata  (xfer_rdata)
    );

endmodule

`default_nettype wire

// File: tb_mapper.sv
// Self-checking testbench for the memory mapper.
// Drives the AXI4-Lite register port, the CPU bus and a req/ack memory model,
// and checks region decode, wait states and transfers against a reference model.
`timescale 1ns/10ps
`default_nettype none
`include "mapper_macros.svh"

module tb_mapper;

    import mapper_pkg::*;

    // roughly 3000 cycles of stimulus, limit leaves a wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic                     clk;
    logic                     rst;
    logic [4:0]               awaddr;
    logic                     awvalid;
    logic                     awready;
    logic [31:0]              wdata;
    logic [3:0]               wstrb;
    logic                     wvalid;
    logic                     wready;
    logic [1:0]               bresp;
    logic                     bvalid;
    logic                     bready;
    logic [4:0]               araddr;
    logic                     arvalid;
    logic                     arready;
    logic [31:0]              rdata;
    logic [1:0]               rresp;
    logic                     rvalid;
    logic                     rready;
    logic [`MAP_AW:1]         addr;
    logic                     asn;
    logic                     ext_ack;
    logic                     dtackn;
    logic [`MAP_REGIONS-1:0]  active;
    logic                     none;
    logic [`MAP_AW:1]         bus_addr;
    logic                     mem_req;
    logic                     mem_we;
    logic [15:0]              mem_wdata;
    logic                     mem_ack = 1'b0;    // driven by the memory model
    logic [15:0]              mem_rdata = 16'd0;

    int               errors = 0;
    int               checks = 0;
    int               cycle_cnt = 0;
    logic [31:0]      seed = 32'h780d;
    logic [31:0]      mem_seed = 32'h780d;     // own stream for the memory model
    region_ctrl_t     ref_ctrl [0:`MAP_REGIONS-1];
    logic [7:0]       ref_base [0:`MAP_REGIONS-1];
    logic [7:0]       shadow [0:`MAP_NREGS-1];
    logic [`MAP_AW:1] exp_addr = '0;
    int               xfer_cnt = 0;
    int               mem_delay;
    logic             got_we;
    logic [`MAP_AW:1] got_addr;
    logic [15:0]      got_wdata;
    logic [15:0]      got_rdata;

    mapper_top u_mapper_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] next_rand();
        seed = lcg_step(seed);
        return {seed[15:0], seed[31:16]};  // high bits are the better ones
    endfunction

    // expected {wait_code, none, active} for a bus address
    function automatic logic [10:0] decode_ref(input logic [`MAP_AW:1] a);
        logic [7:0] act;
        logic [1:0] wc;
        int         shift;
        act = 8'd0;
        wc  = 2'd0;
        for (int r = `MAP_REGIONS - 1; r >= 0; r--) begin  // last hit is the lowest region
            case (ref_ctrl[r].f.size_code)
                2'd0:    shift = 0;
                2'd1:    shift = 1;
                2'd2:    shift = 3;
                default: shift = 5;
            endcase
            if ((a[`MAP_AW -: 8] >> shift) == (ref_base[r] >> shift)) begin
                act = 8'd1 << r;
                wc  = ref_ctrl[r].f.wait_code;
            end
        end
        return {wc, (act == 8'd0), act};
    endfunction

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [`MAP_AW:1] got,
                              input logic [`MAP_AW:1] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_active(input logic [`MAP_REGIONS-1:0] got_act, input logic got_none,
                                input logic [10:0] exp);
        checks++;
        if (got_act !== exp[7:0] || got_none !== exp[8]) begin
            errors++;
            $display("Fail active/none got %h/%h expected %h/%h", got_act, got_none,
                     exp[7:0], exp[8]);
        end
    endtask

    task automatic axi_write(input logic [4:0] a, input logic [7:0] d);
        @(negedge clk);
        awaddr  = a;
        wdata   = {24'd0, d};
        wstrb   = 4'h1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        check_byte("wready", {7'd0, wready}, 8'd1);  // rises with awready
        @(negedge clk);                    // handshake taken on the last edge
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        check_byte("bresp", {6'd0, bresp}, 8'd0);
        @(negedge clk);
    endtask

    task automatic axi_read(input logic [4:0] a, output logic [7:0] d);
        @(negedge clk);
        araddr  = a;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        d = rdata[7:0];
        check_byte("rresp", {6'd0, rresp}, 8'd0);
        @(negedge clk);
    endtask

    task automatic wait_idle();
        logic [7:0] v;
        v = 8'h80;
        while (v[7]) begin
            axi_read(5'd5, v);             // bit 7 is busy
        end
    endtask

    task automatic program_region(input int r, input logic [7:0] ctrl, input logic [7:0] base);
        ref_ctrl[r].raw = ctrl;
        ref_base[r]     = base;
        axi_write(5'(16 + 2 * r), ctrl);
        axi_write(5'(17 + 2 * r), base);
    endtask

    task automatic check_bus();
        check_addr("bus_addr", bus_addr, exp_addr);
        check_active(active, none, decode_ref(exp_addr));
    endtask

    // memory model, answers each request after 0..3 cycles
    always begin
        @(negedge clk);
        if (mem_req) begin
            mem_seed  = lcg_step(mem_seed);
            mem_delay = int'(mem_seed[31:30]);
            check_bus();
            repeat (mem_delay) begin
                @(negedge clk);
                check_bus();
            end
            got_we    = mem_we;
            got_addr  = bus_addr;
            got_wdata = mem_wdata;
            got_rdata = mem_seed[23:8];
            mem_rdata = got_rdata;
            mem_ack   = 1'b1;
            xfer_cnt++;
            @(negedge clk);
            mem_ack   = 1'b0;
        end
    end

    task automatic run_transfer(input logic write);
        logic [31:0]      r32;
        logic [`MAP_AW:1] ta;
        logic [15:0]      td;
        logic [7:0]       v;
        int               cnt0;
        r32 = next_rand();
        ta  = r32[22:0];
        ta[`MAP_AW -: 8] = ref_base[r32[26:24]];  // land inside a programmed region
        td  = next_rand();
        exp_addr = ta;
        addr     = ~ta;                           // CPU address must not leak through
        cnt0     = xfer_cnt;
        axi_write(write ? 5'd10 : 5'd7, {1'b0, ta[23:17]});
        axi_write(write ? 5'd11 : 5'd8, ta[16:9]);
        axi_write(write ? 5'd12 : 5'd9, ta[8:1]);
        axi_write(5'd0, td[15:8]);
        axi_write(5'd1, td[7:0]);
        axi_write(5'd5, write ? {6'd0, `CMD_WRITE} : {6'd0, `CMD_READ});
        wait_idle();
        if (xfer_cnt != cnt0 + 1) begin
            errors++;
            $display("Transfer count wrong: %0d memory cycles seen for one command",
                     xfer_cnt - cnt0);
        end
        check_byte("mem_we", {7'd0, got_we}, {7'd0, write});
        check_addr("transfer address", got_addr, ta);
        if (write) begin
            check_word("mem_wdata", got_wdata, td);
        end else begin
            axi_read(5'd0, v);
            check_byte("reg0", v, got_rdata[15:8]);
            axi_read(5'd1, v);
            check_byte("reg1", v, got_rdata[7:0]);
        end
    endtask

    initial begin
        logic [31:0]      r32;
        logic [7:0]       v;
        logic [7:0]       exp;
        logic [7:0]       n;
        logic [`MAP_AW:1] a;

        rst     = 1'b1;
        awaddr  = 5'd0;
        awvalid = 1'b0;
        wdata   = 32'd0;
        wstrb   = 4'h0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = 5'd0;
        arvalid = 1'b0;
        rready  = 1'b1;
        addr    = '0;
        asn     = 1'b1;
        ext_ack = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // register read-back, command byte kept free of start codes
        for (int i = 0; i < `MAP_NREGS; i++) begin
            r32 = next_rand();
            v   = r32[15:8];
            if (i == 5) v[1:0] = 2'b00;
            shadow[i] = v;
            axi_write(i[4:0], v);
        end
        for (int i = 0; i < `MAP_NREGS; i++) begin
            axi_read(i[4:0], v);
            exp = shadow[i];
            if (i == 5) exp[7] = 1'b0;      // busy bit
            check_byte("rdata", v, exp);
        end

        // region decode with heavy overlap, bases all below 8'h80
        for (int r = 0; r < `MAP_REGIONS; r++) begin
            r32 = next_rand();
            program_region(r, {4'h0, r32[9:8], r32[11:10]}, {1'b0, r32[6:0]});
        end
        for (int k = 0; k < 200; k++) begin
            r32 = next_rand();
            a   = r32[22:0];
            if (r32[31]) a[`MAP_AW -: 8] = ref_base[r32[30:28]];
            @(negedge clk);
            addr = a;
            @(negedge clk);
            check_active(active, none, decode_ref(a));
        end

        // wait states through region 0, which always wins
        for (int w = 0; w < 3; w++) begin
            program_region(0, {4'h0, w[1:0], 2'd3}, 8'h00);
            r32  = next_rand();
            addr = {3'b000, r32[19:0]};
            asn  = 1'b0;
            n    = 8'd0;
            do begin
                @(negedge clk);
                n++;
            end while (dtackn && n < 8'd8);
            if (dtackn) begin
                errors++;
                $display("dtackn never fell for wait code %0d", w);
            end else begin
                check_byte("dtack cycles", n - 8'd1, {6'd0, w[1:0]} + 8'd1);
            end
            asn = 1'b1;
            @(negedge clk);
            check_byte("dtackn", {7'd0, dtackn}, 8'd1);
        end
        program_region(0, {4'h0, 2'd3, 2'd3}, 8'h00);
        asn = 1'b0;
        repeat (6) begin
            @(negedge clk);
            check_byte("dtackn", {7'd0, dtackn}, 8'd1);
        end
        ext_ack = 1'b1;
        @(negedge clk);
        ext_ack = 1'b0;
        check_byte("dtackn", {7'd0, dtackn}, 8'd0);
        asn = 1'b1;
        @(negedge clk);
        check_byte("dtackn", {7'd0, dtackn}, 8'd1);

        // software transfers, writes and reads interleaved
        for (int k = 0; k < 4; k++) begin
            run_transfer(1'b1);
            run_transfer(1'b0);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
mapper_pkg.sv
mapper_regs.sv
region_decode.sv
wait_timer.sv
xfer_fsm.sv
mapper_top.sv
tb_mapper.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mapper
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard *.sv) $(wildcard *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
